// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_zx81_ula
FILELIST  = zx81_ula.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== hdl/display_timing.sv ====
//====================
// Re-synchronised display timing
//====================

`timescale 1ns/100ps

`include "zx81_params.svh"

module display_timing import zx81_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ce_pix,
	input  logic        hsync,
	input  logic        vsync_raw,
	output video_sync_t video
);

	logic [`DISP_CNT_BITS-1:0] disp_cnt;
	logic [`VS_HIST_DEPTH-1:0] vs_hist;
	logic                      disp_hs;
	logic                      hblank;
	logic                      hsync_d;
	logic                      hsync_rise;

	assign hsync_rise = hsync & ~hsync_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			disp_cnt <= '0;
			vs_hist  <= '0;
			disp_hs  <= 1'b0;
			hblank   <= 1'b0;
			hsync_d  <= 1'b0;
		end else begin
			hsync_d <= hsync;

			// Steady 414 step line
			if (ce_pix) begin
				if (disp_cnt == `DISP_LAST)
					disp_cnt <= '0;
				else
					disp_cnt <= disp_cnt + 1'b1;

				if (disp_cnt == '0)
					disp_hs <= 1'b1;
				else if (disp_cnt == `DISP_HS_OFF)
					disp_hs <= 1'b0;

				// Blank wraps across the line end
				if (disp_cnt == `HBLANK_ON)
					hblank <= 1'b1;
				else if (disp_cnt == `HBLANK_OFF)
					hblank <= 1'b0;
			end

			// Line history of the raw vsync
			if (hsync_rise) begin
				vs_hist <= {vs_hist[`VS_HIST_DEPTH-2:0], vsync_raw};
				// Realign on a settled vertical sync
				if (&vs_hist[3:2])
					disp_cnt <= '0;
			end
		end
	end

	assign video = '{hsync: disp_hs, vsync: vs_hist[2], hblank: hblank,
		vblank: |{vs_hist, vsync_raw}};

endmodule

// ==== hdl/joy_map.sv ====
//====================
// Joystick to keyboard column mapping
//====================

`timescale 1ns/100ps

module joy_map import zx81_pkg::*; (
	input  joy_t       joy,
	input  joy_mode_t  joy_mode,
	input  logic [1:0] addr_hi,
	output logic [4:0] joy_cols
);

	// Pressed keys, active high, per half-row
	logic [4:0] row_67890;
	logic [4:0] row_12345;

	always_comb begin
		row_67890 = 5'b00000;
		row_12345 = 5'b00000;

		case (joy_mode)
			zx81: begin
				row_67890 = {joy.down, joy.up, joy.right, joy.left, joy.fire};
			end
			sinclair: begin
				// Interface 2 style, 6 to 0
				row_67890 = {joy.left, joy.right, joy.down, joy.up, joy.fire};
			end
			cursor: begin
				row_67890 = {joy.down, joy.up, joy.right, 1'b0, joy.fire};
				// Left arrow lives on key 5
				row_12345 = {joy.left, 4'b0000};
			end
			default: begin
				row_67890 = 5'b00000;
				row_12345 = 5'b00000;
			end
		endcase
	end

	// A12 low selects 67890, A11 low selects 12345
	assign joy_cols = ~(({5{~addr_hi[1]}} & row_67890) |
		({5{~addr_hi[0]}} & row_12345));

endmodule

// ==== hdl/line_sync.sv ====
//====================
// Clock enable divider and line sync counter
//====================

`timescale 1ns/100ps

`include "zx81_params.svh"

module line_sync import zx81_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  io_strobe_t strobes,
	output logic       ce_pix,
	output logic       hsync
);

	logic [`CE_DIV_BITS-1:0]   ce_div;
	logic [`LINE_CNT_BITS-1:0] sync_cnt;
	logic                      ce_line;

	// Free running divider
	always_ff @(posedge clk_sys) begin
		if (reset)
			ce_div <= '0;
		else
			ce_div <= ce_div + 1'b1;
	end

	// Pixel rate is twice the line step rate
	assign ce_pix  = (ce_div[`CE_DIV_BITS-2:0] == '0);
	assign ce_line = (ce_div == '0);

	//====================
	// Horizontal sync
	//====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sync_cnt <= '0;
			hsync    <= 1'b0;
		end else if (strobes.int_ack) begin
			// INT ack restarts the line like the real ULA
			sync_cnt <= '0;
			hsync    <= 1'b0;
		end else if (ce_line) begin
			if (sync_cnt == `LINE_LAST)
				sync_cnt <= '0;
			else
				sync_cnt <= sync_cnt + 1'b1;

			if (sync_cnt == `HSYNC_ON)
				hsync <= 1'b1;
			else if (sync_cnt == `HSYNC_OFF)
				hsync <= 1'b0;
		end
	end

endmodule

// ==== hdl/nmi_vsync.sv ====
//====================
// NMI generator latch and vertical sync level
//====================

`timescale 1ns/100ps

module nmi_vsync import zx81_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  io_strobe_t strobes,
	input  logic       hsync,
	output logic       nmi_n,
	output logic       vsync_raw
);

	logic nmi_latch;
	logic vs;

	// NMI generator on/off by port write
	always_ff @(posedge clk_sys) begin
		if (reset)
			nmi_latch <= 1'b0;
		else if (strobes.nmi_on)
			nmi_latch <= 1'b1;
		else if (strobes.nmi_off)
			nmi_latch <= 1'b0;
	end

	// One NMI per line while the generator runs
	assign nmi_n = ~(nmi_latch & hsync);

	//====================
	// Vertical sync
	//====================

	// Keyboard read starts vsync, any OUT ends it.
	// Both are ignored while NMIs are on
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vs        <= 1'b0;
			vsync_raw <= 1'b0;
		end else begin
			if (strobes.kbd_rd && !nmi_latch)
				vs <= 1'b1;
			else if (strobes.io_wr && !nmi_latch)
				vs <= 1'b0;

			// Clean copy only moves outside hsync
			if (!hsync)
				vsync_raw <= vs;
		end
	end

endmodule

// ==== hdl/port_decode.sv ====
//====================
// I/O strobe decoder
//====================

`timescale 1ns/100ps

`include "zx81_params.svh"

module port_decode import zx81_pkg::*; (
	input  z80_bus_t   bus,
	output io_strobe_t strobes
);

	logic io_cycle;
	logic io_rd;
	logic io_wr;
	logic zxp_hit;

	// Plain I/O cycle, never a memory cycle
	assign io_cycle = bus.iorq & ~bus.mreq;
	assign io_rd    = io_cycle & bus.rd;
	assign io_wr    = io_cycle & bus.wr;

	// Printer port needs the full 16-bit address
	assign zxp_hit = (bus.addr == `ZXP_PORT);

	always_comb begin
		// Keyboard answers any even port
		strobes.kbd_rd  = io_rd & ~bus.addr[0];
		strobes.io_wr   = io_wr;

		// A1/A0 pattern picks NMI on or off
		strobes.nmi_on  = io_wr & bus.addr[1] & ~bus.addr[0];
		strobes.nmi_off = io_wr & bus.addr[0] & ~bus.addr[1];

		// M1 with IORQ is the interrupt acknowledge
		strobes.int_ack = bus.m1 & bus.iorq;

		strobes.zxp_wr  = io_wr & zxp_hit;
		strobes.zxp_rd  = io_rd & zxp_hit;
	end

endmodule

// ==== hdl/port_read.sv ====
//====================
// Printer joystick port and I/O read data
//====================

`timescale 1ns/100ps

`include "zx81_params.svh"

module port_read import zx81_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  io_strobe_t strobes,
	input  z80_bus_t   bus,
	input  logic [4:0] key_cols,
	input  logic [4:0] joy_cols,
	input  joy_t       joy,
	input  logic       hz50,
	output logic [7:0] rdata
);

	logic [7:0] zxp_reg;
	logic       zxp_use;
	logic [4:0] joy_kbd;

	// Printer port commands
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zxp_reg <= 8'hFF;
			zxp_use <= 1'b0;
		end else if (strobes.zxp_wr) begin
			case (bus.wdata)
				`ZXP_CMD_HI:  zxp_reg <= 8'hF0;
				`ZXP_CMD_LO:  zxp_reg <= 8'h0F;
				`ZXP_CMD_JOY: begin
					zxp_reg <= {~joy.up, ~joy.down, ~joy.left, ~joy.right,
						~joy.fire, 3'b000};
					// Software reads the stick here from now on
					zxp_use <= 1'b1;
				end
				default:      zxp_reg <= 8'hFF;
			endcase
		end
	end

	// Joystick keys drop out once the printer port is in use
	assign joy_kbd = zxp_use ? 5'b11111 : joy_cols;

	//====================
	// Read mux
	//====================

	always_comb begin
		if (strobes.kbd_rd)
			// Tape input is idle low
			rdata = {1'b0, hz50, 1'b0, key_cols & joy_kbd};
		else if (strobes.zxp_rd)
			rdata = zxp_reg;
		else
			rdata = `IO_IDLE;
	end

endmodule

// ==== hdl/zx81_pkg.sv ====
//====================
// Shared types for the ZX81 ULA timing and port logic
//====================

package zx81_pkg;

	// One sample of the Z80 bus, all controls active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        m1;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
	} z80_bus_t;

	// Decoded I/O strobes
	typedef struct packed {
		logic kbd_rd;
		logic io_wr;
		logic nmi_on;
		logic nmi_off;
		logic int_ack;
		logic zxp_wr;
		logic zxp_rd;
	} io_strobe_t;

	// Joystick directions and fire, active high
	typedef struct packed {
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef enum logic [1:0] {
		cursor   = 2'd0,
		sinclair = 2'd1,
		zx81     = 2'd2
	} joy_mode_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
	} video_sync_t;

endpackage

// ==== hdl/zx81_ula_top.sv ====
//====================
// ULA top level with decode, timing, NMI and port read
//====================

`timescale 1ns/100ps

module zx81_ula_top import zx81_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  z80_bus_t    bus,
	input  logic [4:0]  key_cols,
	input  joy_t        joy,
	input  joy_mode_t   joy_mode,
	input  logic        hz50,
	output logic [7:0]  rdata,
	output logic        nmi_n,
	output video_sync_t video
);

	io_strobe_t strobes;
	logic       ce_pix;
	logic       hsync;
	logic       vsync_raw;
	logic [4:0] joy_cols;

	port_decode u_port_decode (
		.bus     (bus),
		.strobes (strobes)
	);

	line_sync u_line_sync (
		.clk_sys (clk_sys),
		.reset   (reset),
		.strobes (strobes),
		.ce_pix  (ce_pix),
		.hsync   (hsync)
	);

	nmi_vsync u_nmi_vsync (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.strobes   (strobes),
		.hsync     (hsync),
		.nmi_n     (nmi_n),
		.vsync_raw (vsync_raw)
	);

	display_timing u_display_timing (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ce_pix    (ce_pix),
		.hsync     (hsync),
		.vsync_raw (vsync_raw),
		.video     (video)
	);

	// Half-row select comes from A12 and A11
	joy_map u_joy_map (
		.joy      (joy),
		.joy_mode (joy_mode),
		.addr_hi  (bus.addr[12:11]),
		.joy_cols (joy_cols)
	);

	port_read u_port_read (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.strobes  (strobes),
		.bus      (bus),
		.key_cols (key_cols),
		.joy_cols (joy_cols),
		.joy      (joy),
		.hz50     (hz50),
		.rdata    (rdata)
	);

endmodule

// ==== include/zx81_params.svh ====
//====================
// Counter limits, sync and blank points, port constants
//====================

`ifndef ZX81_PARAMS_SVH
`define ZX81_PARAMS_SVH

// Clock enable divider, 2**CE_DIV_BITS clk_sys cycles per 3.25 MHz step
`define CE_DIV_BITS   4

// Line sync counter, 207 steps per line
`define LINE_CNT_BITS 8
`define LINE_LAST     8'd206
`define HSYNC_ON      8'd15
`define HSYNC_OFF     8'd31

// Re-synchronised display counter, 414 steps per line
`define DISP_CNT_BITS 9
`define DISP_LAST     9'd413
`define DISP_HS_OFF   9'd32
`define HBLANK_ON     9'd400
`define HBLANK_OFF    9'd72

// Lines of vsync history
`define VS_HIST_DEPTH 5

// ZX printer joystick port
`define ZXP_PORT      16'hE007
`define ZXP_CMD_HI    8'hAA
`define ZXP_CMD_LO    8'h55
`define ZXP_CMD_JOY   8'hA0

// Floating data bus
`define IO_IDLE       8'hFF

`endif

// ==== verif/tb_zx81_ula.sv ====
//====================
// Testbench top with clock, reset and bus-cycle stimulus
//====================

`timescale 1ns/100ps

module tb_zx81_ula import zx81_pkg::*;;

	logic        clk_sys;
	logic        reset;
	z80_bus_t    bus;
	logic [4:0]  key_cols;
	joy_t        joy;
	joy_mode_t   joy_mode;
	logic        hz50;
	logic [7:0]  rdata;
	logic        nmi_n;
	video_sync_t video;

	integer seed = 32'hdc1252fd;

	localparam int LINE = 3312;

	zx81_ula_top DUT (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.key_cols (key_cols),
		.joy      (joy),
		.joy_mode (joy_mode),
		.hz50     (hz50),
		.rdata    (rdata),
		.nmi_n    (nmi_n),
		.video    (video)
	);

	ula_checker u_checker (.*);

	always #4 clk_sys = ~clk_sys;

	function automatic z80_bus_t io_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic is_wr);
		z80_bus_t b;
		b = '0;
		b.addr = addr;
		b.wdata = data;
		b.iorq = 1'b1;
		b.wr = is_wr;
		b.rd = ~is_wr;
		return b;
	endfunction

	// Holds one bus cycle for 4 clocks
	task automatic run_cycle(input z80_bus_t b);
		@(posedge clk_sys);
		bus <= b;
		repeat (4) @(posedge clk_sys);
		bus <= '0;
	endtask

	task automatic randomize_inputs();
		logic [31:0] r;
		r = $random(seed);
		@(posedge clk_sys);
		key_cols <= r[4:0];
		joy <= joy_t'(r[9:5]);
		joy_mode <= (r[11:10] == 2'd3) ? zx81 : joy_mode_t'(r[11:10]);
		hz50 <= r[12];
	endtask

	initial begin
		int n;
		int low;
		int high;
		int period;
		int blank;
		logic [31:0] r;
		logic [7:0] cmds [4];

		clk_sys = 1'b0;
		reset = 1'b1;
		bus = '0;
		key_cols = 5'b11111;
		joy = '0;
		joy_mode = cursor;
		hz50 = 1'b0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;

		// 1. NMI pulses follow the line sync
		u_checker.start_test("line sync");
		u_checker.expect_steady(0, 1'b1, 4000);
		run_cycle(io_cycle(16'h00FE, 8'h00, 1'b1));
		u_checker.wait_level(0, 1'b1, 400, n);
		u_checker.wait_level(0, 1'b0, 4000, n);
		for (int i = 0; i < 2; i++) begin
			u_checker.wait_level(0, 1'b1, 400, low);
			u_checker.wait_level(0, 1'b0, 4000, high);
			u_checker.check_range("nmi_n low pulse", low, 256, 256);
			u_checker.check_range("nmi_n pulse spacing", low + high, LINE, LINE);
		end
		u_checker.finish_test();

		// 2. INT ack inside an NMI pulse
		u_checker.start_test("interrupt acknowledge");
		u_checker.wait_level(0, 1'b1, 400, n);
		u_checker.wait_level(0, 1'b0, 4000, n);
		repeat (50) @(posedge clk_sys);
		@(posedge clk_sys);
		bus <= '{addr: 16'h0038, wdata: 8'h00, m1: 1'b1, mreq: 1'b0, iorq: 1'b1,
			rd: 1'b0, wr: 1'b0};
		u_checker.wait_level(0, 1'b1, 3, n);
		u_checker.check_range("nmi_n release after INT ack", n, 1, 2);
		repeat (3) @(posedge clk_sys);
		bus <= '0;
		u_checker.wait_level(0, 1'b0, 400, n);
		u_checker.check_range("next nmi_n pulse after INT ack", n, 240, 272);
		u_checker.finish_test();

		// 3. Vertical sync with NMIs off
		u_checker.start_test("vertical sync");
		run_cycle(io_cycle(16'h00FD, 8'h00, 1'b1));
		run_cycle(io_cycle(16'hFEFE, 8'h00, 1'b0));
		u_checker.wait_level(1, 1'b1, 6 * LINE, n);
		u_checker.wait_level(2, 1'b1, 6 * LINE, n);
		repeat (LINE) @(posedge clk_sys);
		run_cycle(io_cycle(16'h00FF, 8'h00, 1'b1));
		u_checker.wait_level(1, 1'b0, 6 * LINE, n);
		u_checker.wait_level(2, 1'b0, 6 * LINE, n);
		u_checker.finish_test();

		// 4. Display hsync and hblank
		u_checker.start_test("display timing");
		u_checker.wait_level(4, 1'b0, 4000, n);
		u_checker.wait_level(4, 1'b1, 4000, n);
		for (int i = 0; i < 2; i++) begin
			u_checker.measure_line(period, blank);
			u_checker.check_range("video.hsync period", period, LINE, LINE);
			u_checker.check_range("video.hblank high time", blank, 688, 688);
		end
		u_checker.finish_test();

		// 5. Random keyboard reads
		u_checker.start_test("keyboard port");
		for (int i = 0; i < 40; i++) begin
			randomize_inputs();
			r = $random(seed);
			run_cycle(io_cycle({3'b111, r[1:0], 11'h0FE}, 8'h00, 1'b0));
		end
		u_checker.finish_test();

		// 6. Printer joystick port
		u_checker.start_test("printer port");
		r = $random(seed);
		cmds[0] = 8'hAA;
		cmds[1] = 8'h55;
		cmds[2] = 8'hA0;
		cmds[3] = r[7:0];
		foreach (cmds[i]) begin
			randomize_inputs();
			run_cycle(io_cycle(16'hE007, cmds[i], 1'b1));
			run_cycle(io_cycle(16'hE007, 8'h00, 1'b0));
			if (cmds[i] == 8'hA0) begin
				for (int k = 0; k < 8; k++) begin
					randomize_inputs();
					r = $random(seed);
					run_cycle(io_cycle({3'b111, r[1:0], 11'h0FE}, 8'h00, 1'b0));
				end
			end
		end
		u_checker.finish_test();

		u_checker.report_counts();
		if (u_checker.tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== verif/ula_checker.sv ====
//====================
// Reference model, comparing processes and per-test results
//====================

`timescale 1ns/100ps

`include "zx81_params.svh"

module ula_checker import zx81_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  z80_bus_t    bus,
	input  logic [4:0]  key_cols,
	input  joy_t        joy,
	input  joy_mode_t   joy_mode,
	input  logic        hz50,
	input  logic [7:0]  rdata,
	input  logic        nmi_n,
	input  video_sync_t video
);

	int    tests_run = 0;
	int    tests_failed = 0;
	int    err_total = 0;
	int    test_errs = 0;
	int    test_checks = 0;
	string cur_name = "";

	// Printer port model
	logic [7:0] prn_reg;
	logic       prn_use;

	// Expected byte for an I/O read
	function automatic logic [7:0] ref_read(input logic [15:0] addr, input logic [4:0] keys,
		input joy_t j, input joy_mode_t mode, input logic h50, input logic [7:0] prn,
		input logic use_prn);
		logic [4:0] pressed;
		pressed = 5'b00000;
		if (!addr[0]) begin
			if (!addr[12]) begin
				if (mode == zx81)
					pressed = {j.down, j.up, j.right, j.left, j.fire};
				else if (mode == sinclair)
					pressed = {j.left, j.right, j.down, j.up, j.fire};
				else if (mode == cursor)
					pressed = {j.down, j.up, j.right, 1'b0, j.fire};
			end
			// Cursor left is key 5 on the other half-row
			if (!addr[11] && mode == cursor)
				pressed[4] = pressed[4] | j.left;
			if (use_prn)
				pressed = 5'b00000;
			return {1'b0, h50, 1'b0, keys & ~pressed};
		end else if (addr == `ZXP_PORT) begin
			return prn;
		end
		return `IO_IDLE;
	endfunction

	function automatic logic sig_value(input int which);
		case (which)
			0:       return nmi_n;
			1:       return video.vsync;
			2:       return video.vblank;
			3:       return video.hblank;
			default: return video.hsync;
		endcase
	endfunction

	function automatic string sig_name(input int which);
		case (which)
			0:       return "nmi_n";
			1:       return "video.vsync";
			2:       return "video.vblank";
			3:       return "video.hblank";
			default: return "video.hsync";
		endcase
	endfunction

	//====================
	// Comparing process
	//====================

	always @(negedge clk_sys) begin
		if (reset) begin
			prn_reg <= 8'hFF;
			prn_use <= 1'b0;
		end else if (bus.iorq && !bus.mreq) begin
			if (bus.rd) begin
				test_checks++;
				if (rdata !== ref_read(bus.addr, key_cols, joy, joy_mode, hz50,
					prn_reg, prn_use)) begin
					$display("MISMATCH rdata addr=%h got=%h expected=%h", bus.addr, rdata,
						ref_read(bus.addr, key_cols, joy, joy_mode, hz50, prn_reg, prn_use));
					test_errs++;
				end
			end
			if (bus.wr && bus.addr == `ZXP_PORT) begin
				if (bus.wdata == 8'hAA) begin
					prn_reg <= 8'hF0;
				end else if (bus.wdata == 8'h55) begin
					prn_reg <= 8'h0F;
				end else if (bus.wdata == 8'hA0) begin
					prn_reg <= {~joy.up, ~joy.down, ~joy.left, ~joy.right, ~joy.fire, 3'b000};
					prn_use <= 1'b1;
				end else begin
					prn_reg <= 8'hFF;
				end
			end
		end
	end

	task automatic start_test(input string name);
		cur_name = name;
		test_errs = 0;
		test_checks = 0;
		tests_run++;
	endtask

	task automatic finish_test();
		if (test_errs == 0 && test_checks > 0) begin
			$display("Test %0d %s: ok, %0d checks", tests_run, cur_name, test_checks);
		end else begin
			if (test_checks == 0)
				$display("Test %0d %s: nothing was checked", tests_run, cur_name);
			$display("Test %0d %s: FAILED, %0d errors", tests_run, cur_name, test_errs);
			tests_failed++;
			err_total += test_errs;
		end
	endtask

	// Waits on negedges until the signal reaches the level
	task automatic wait_level(input int which, input logic level, input int limit,
		output int cycles);
		cycles = 0;
		while (sig_value(which) !== level && cycles < limit) begin
			@(negedge clk_sys);
			cycles++;
		end
		test_checks++;
		if (sig_value(which) !== level) begin
			$display("Timeout: %s did not reach %0d within %0d cycles", sig_name(which),
				level, limit);
			test_errs++;
		end
	endtask

	task automatic expect_steady(input int which, input logic level, input int cycles);
		int bad;
		bad = 0;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk_sys);
			if (sig_value(which) !== level)
				bad++;
		end
		test_checks++;
		if (bad != 0) begin
			$display("%s left %0d for %0d of %0d cycles", sig_name(which), level, bad, cycles);
			test_errs++;
		end
	endtask

	task automatic check_range(input string what, input int got, input int lo, input int hi);
		test_checks++;
		if (got < lo || got > hi) begin
			$display("%s was %0d cycles, expected %0d to %0d", what, got, lo, hi);
			test_errs++;
		end
	endtask

	// Measures one display line from hsync rise to rise and counts hblank cycles.
	// Starts on a cycle where hsync is already high
	task automatic measure_line(output int period, output int blank);
		period = 0;
		blank = 0;
		while (video.hsync === 1'b1 && period < 4000) begin
			@(negedge clk_sys);
			period++;
			if (video.hblank === 1'b1)
				blank++;
		end
		while (video.hsync !== 1'b1 && period < 4000) begin
			@(negedge clk_sys);
			period++;
			if (video.hblank === 1'b1)
				blank++;
		end
	endtask

	task automatic report_counts();
		$display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			err_total);
	endtask

endmodule

// ==== zx81_ula.f ====
+incdir+include
hdl/zx81_pkg.sv
hdl/port_decode.sv
hdl/line_sync.sv
hdl/nmi_vsync.sv
hdl/display_timing.sv
hdl/joy_map.sv
hdl/port_read.sv
hdl/zx81_ula_top.sv
verif/ula_checker.sv
verif/tb_zx81_ula.sv
